//--- src/fnd_consts.svh
`ifndef FND_CONSTS_SVH
`define FND_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define FND_COUNT_WIDTH   12  // binary count, wraps at 4095
`define FND_DIGITS        4   // digits on the display
`define FND_NIBBLE_WIDTH  4   // one hex or decimal digit
`define FND_BCD_WIDTH     16  // four packed decimal digits
`define FND_SEG_WIDTH     8   // a..g plus decimal point

//////////////////////////////////////////////////////////////////////
// default timing
//////////////////////////////////////////////////////////////////////

// clocks per count step while run is high
`define FND_TICK_DIV      4

// scan divider width, com steps every 2**bits clocks
`define FND_SCAN_DIV_BITS 3

`endif

//--- src/fnd_pkg.sv
`default_nettype none

package fnd_pkg;

    `include "fnd_consts.svh"

    // binary count from the tick counter
    typedef logic [`FND_COUNT_WIDTH-1:0] count_t;

    // four decimal digits, units in [3:0]
    typedef logic [`FND_BCD_WIDTH-1:0] bcd_t;

    typedef logic [`FND_NIBBLE_WIDTH-1:0] nibble_t; // one digit value

    // active-low digit common, exactly one bit low
    // 1110 is the units digit, 0111 the most significant
    typedef logic [`FND_DIGITS-1:0] com_t;

    // active-low segments, a in bit 7 down to g in bit 1, dp in bit 0
    typedef logic [`FND_SEG_WIDTH-1:0] seg_t;

endpackage : fnd_pkg

`default_nettype wire

//--- src/tick_counter.sv
`default_nettype none

`include "fnd_consts.svh"

module tick_counter
    import fnd_pkg::*;
#(
    parameter int TICK_DIV = `FND_TICK_DIV
) (
    input  wire    clk,
    input  wire    reset_p,
    input  logic   run,
    output count_t count
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICK_DIV - 1);

    logic [PRE_W-1:0] prescale; // run-high clocks since last step

    //////////////////////////////////////////////////////////////////////
    // prescaler and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            prescale <= '0;
            count    <= '0;
        end
        else if (run) begin
            if (prescale == PRE_LAST) begin
                prescale <= '0;
                count    <= count + 1'b1; // wraps 4095 -> 0
            end
            else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // any change of count is a single step taken in a run-high cycle
    a_count_step : assert property (
        @(posedge clk) disable iff (reset_p)
        (count != $past(count)) |->
            ($past(run) && (count == count_t'($past(count) + 1'b1)))
    ) else $error("tick_counter: count moved from %0d to %0d", $past(count), count);

endmodule : tick_counter

`default_nettype wire

//--- src/bin_to_bcd.sv
`default_nettype none

`include "fnd_consts.svh"

module bin_to_bcd
    import fnd_pkg::*;
(
    input  count_t bin,
    output bcd_t   bcd
);

    localparam int NW = `FND_NIBBLE_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // shift-and-add-3
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bcd_t acc;
        acc = '0;
        for (int i = 0; i < `FND_COUNT_WIDTH; i++) begin
            acc = {acc[`FND_BCD_WIDTH-2:0], bin[`FND_COUNT_WIDTH-1-i]}; // msb first
            // correct digits ahead of the next shift, none after the last
            if (i < `FND_COUNT_WIDTH - 1) begin
                for (int j = 0; j < `FND_DIGITS; j++) begin
                    if (acc[j*NW +: NW] > nibble_t'(4))
                        acc[j*NW +: NW] = acc[j*NW +: NW] + nibble_t'(3);
                end
            end
        end
        bcd = acc;
    end

    // no clock here, so the digit range check is a deferred immediate one
    always_comb begin
        for (int j = 0; j < `FND_DIGITS; j++) begin
            a_digit_range : assert final (bcd[j*NW +: NW] <= nibble_t'(9))
                else $error("bin_to_bcd: digit %0d is %0h for input %0d",
                            j, bcd[j*NW +: NW], bin);
        end
    end

endmodule : bin_to_bcd

`default_nettype wire

//--- src/digit_scanner.sv
`default_nettype none

`include "fnd_consts.svh"

module digit_scanner
    import fnd_pkg::*;
#(
    parameter int SCAN_DIV_BITS = `FND_SCAN_DIV_BITS
) (
    input  wire     clk,
    input  wire     reset_p,
    input  count_t  count,
    input  bcd_t    bcd,
    input  logic    hex_mode,
    output com_t    com,
    output nibble_t digit
);

    logic [SCAN_DIV_BITS-1:0] scan_div; // free-running
    logic                     ff_cur;
    logic                     ff_old;
    logic                     step;     // one clock per divider rising edge
    bcd_t                     shown;    // the four nibbles on offer

    //////////////////////////////////////////////////////////////////////
    // scan divider and edge detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_div <= '0;
            ff_cur   <= 1'b0;
            ff_old   <= 1'b0;
        end
        else begin
            scan_div <= scan_div + 1'b1;
            ff_cur   <= scan_div[SCAN_DIV_BITS-1];
            ff_old   <= ff_cur;
        end
    end

    assign step = ff_cur & ~ff_old;

    //////////////////////////////////////////////////////////////////////
    // common ring
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com <= 4'b1110;
        end
        else if (step) begin
            case (com)
                4'b1110: com <= 4'b1101;
                4'b1101: com <= 4'b1011;
                4'b1011: com <= 4'b0111;
                4'b0111: com <= 4'b1110;
                default: com <= 4'b1110; // recover from a bad state
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // digit select, registered
    //////////////////////////////////////////////////////////////////////

    // hex view pads the 12-bit count with a zero top nibble
    assign shown = hex_mode ? {{(`FND_BCD_WIDTH - `FND_COUNT_WIDTH){1'b0}}, count} : bcd;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            digit <= '0;
        end
        else begin
            case (com)
                4'b1110: digit <= shown[3:0];   // units
                4'b1101: digit <= shown[7:4];
                4'b1011: digit <= shown[11:8];
                4'b0111: digit <= shown[15:12]; // most significant
                default: digit <= shown[3:0];
            endcase
        end
    end

    a_com_one_low : assert property (
        @(posedge clk) disable iff (reset_p) $onehot(~com)
    ) else $error("digit_scanner: com %b does not have exactly one low bit", com);

endmodule : digit_scanner

`default_nettype wire

//--- src/seg_decoder.sv
`default_nettype none

module seg_decoder
    import fnd_pkg::*;
(
    input  nibble_t digit,
    output seg_t    seg_7
);

    // low bit lights a segment, dp in bit 0 stays dark
    always_comb begin
        case (digit)
            4'h0: seg_7 = 8'b0000_0011;
            4'h1: seg_7 = 8'b1001_1111;
            4'h2: seg_7 = 8'b0010_0101;
            4'h3: seg_7 = 8'b0000_1101;
            4'h4: seg_7 = 8'b1001_1001;
            4'h5: seg_7 = 8'b0100_1001;
            4'h6: seg_7 = 8'b0100_0001;
            4'h7: seg_7 = 8'b0001_1011;
            4'h8: seg_7 = 8'b0000_0001;
            4'h9: seg_7 = 8'b0001_1001;
            4'ha: seg_7 = 8'b0001_0001;
            4'hb: seg_7 = 8'b1100_0001; // lower case b
            4'hc: seg_7 = 8'b0110_0011;
            4'hd: seg_7 = 8'b1000_0101; // lower case d
            4'he: seg_7 = 8'b0110_0001;
            4'hf: seg_7 = 8'b0111_0001;
            default: seg_7 = 8'b1111_1111; // blank
        endcase
    end

endmodule : seg_decoder

`default_nettype wire

//--- src/fnd_counter_top.sv
`default_nettype none

`include "fnd_consts.svh"

module fnd_counter_top
    import fnd_pkg::*;
#(
    parameter int TICK_DIV      = `FND_TICK_DIV,
    parameter int SCAN_DIV_BITS = `FND_SCAN_DIV_BITS
) (
    input  wire    clk,
    input  wire    reset_p,
    input  logic   run,
    input  logic   hex_mode,
    output count_t count,
    output com_t   com,
    output seg_t   seg_7
);

    bcd_t    bcd;   // decimal view of count
    nibble_t digit; // registered nibble for the lit position

    //////////////////////////////////////////////////////////////////////
    // count -> convert -> scan -> decode
    //////////////////////////////////////////////////////////////////////

    tick_counter #(
        .TICK_DIV (TICK_DIV)
    ) u_tick_counter (
        .clk     (clk),
        .reset_p (reset_p),
        .run     (run),
        .count   (count)
    );

    bin_to_bcd u_bin_to_bcd (
        .bin (count),
        .bcd (bcd)
    );

    digit_scanner #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_digit_scanner (
        .clk      (clk),
        .reset_p  (reset_p),
        .count    (count),
        .bcd      (bcd),
        .hex_mode (hex_mode),
        .com      (com),
        .digit    (digit)
    );

    seg_decoder u_seg_decoder (
        .digit (digit),
        .seg_7 (seg_7)
    );

endmodule : fnd_counter_top

`default_nettype wire

//--- sim/fnd_counter_tb.sv
`default_nettype none

`include "fnd_consts.svh"

module fnd_counter_tb
    import fnd_pkg::*;
();

    localparam int TICK_DIV      = 4;
    localparam int SCAN_DIV_BITS = 3;
    localparam int RUN_PCT       = 80; // percent of cycles with run high
    localparam int SCAN_PERIOD   = 2 ** SCAN_DIV_BITS;
    localparam int TIMEOUT_CYCLES = (4 * 4096 * TICK_DIV * 100) / RUN_PCT + 1000;

    logic    clk;
    logic    reset_p;
    logic    run;
    logic    hex_mode;
    count_t  count;
    com_t    com;
    seg_t    seg_7;

    int      hex_left;       // cycles until hex_mode flips
    int      cycles;
    int      m_pre;          // model prescaler
    count_t  m_count;        // model count
    com_t    prev_com;
    count_t  prev_count;
    logic    prev_hex;
    com_t    last_com;       // com at the previous negedge
    count_t  last_count;
    int      since_change;
    logic    seen_change;
    logic    wrapped;

    fnd_counter_top #(
        .TICK_DIV      (TICK_DIV),
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_dut (
        .clk      (clk),
        .reset_p  (reset_p),
        .run      (run),
        .hex_mode (hex_mode),
        .count    (count),
        .com      (com),
        .seg_7    (seg_7)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // adjust then shift with the digits above the binary field
    function automatic bcd_t to_decimal(input count_t bin);
        logic [`FND_BCD_WIDTH+`FND_COUNT_WIDTH-1:0] work;
        work = {{`FND_BCD_WIDTH{1'b0}}, bin};
        for (int s = 0; s < `FND_COUNT_WIDTH; s++) begin
            for (int d = 0; d < `FND_DIGITS; d++) begin
                if (work[`FND_COUNT_WIDTH + 4*d +: 4] >= 4'd5)
                    work[`FND_COUNT_WIDTH + 4*d +: 4] += 4'd3;
            end
            work = work << 1;
        end
        return work[`FND_BCD_WIDTH+`FND_COUNT_WIDTH-1 -: `FND_BCD_WIDTH];
    endfunction

    function automatic nibble_t pick_nibble(input com_t c, input bcd_t value);
        case (c)
            4'b1110: return value[3:0];
            4'b1101: return value[7:4];
            4'b1011: return value[11:8];
            4'b0111: return value[15:12];
            default: return 4'hx;
        endcase
    endfunction

    function automatic com_t next_com(input com_t c);
        return {c[2:0], c[3]}; // rotate the low bit upward
    endfunction

    function automatic seg_t seg_pattern(input nibble_t n);
        seg_t table_hex [16] = '{8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49, 8'h41, 8'h1b,
                                 8'h01, 8'h19, 8'h11, 8'hc1, 8'h63, 8'h85, 8'h61, 8'h71};
        return table_hex[n];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus, model and timeout on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset_p) begin
            run <= ($urandom_range(99) < RUN_PCT);
            if (hex_left == 0) begin
                hex_mode <= ~hex_mode;
                hex_left <= $urandom_range(500, 200);
            end
            else begin
                hex_left <= hex_left - 1;
            end
        end
    end

    always @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            m_pre      <= 0;
            m_count    <= '0;
            prev_com   <= 4'b1110;
            prev_count <= '0;
            prev_hex   <= 1'b0;
        end
        else begin
            if (run) begin
                if (m_pre == TICK_DIV - 1) begin
                    m_pre   <= 0;
                    m_count <= m_count + 1'b1;
                end
                else begin
                    m_pre <= m_pre + 1;
                end
            end
            prev_com   <= com;      // what the digit register sees this edge
            prev_count <= m_count;
            prev_hex   <= hex_mode;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the count did not wrap within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks on the falling edge with settled outputs
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        bcd_t   shown;
        if (reset_p) begin
            last_com     = 4'b1110;
            last_count   = '0;
            since_change = 0;
            seen_change  = 1'b0;
        end
        else begin
            if (last_count == count_t'(4095) && count != last_count) begin
                check_value("wrap", 0, count);
                wrapped = 1'b1;
            end
            check_value("count", m_count, count);
            check_value("com one low", 1, $onehot(~com));
            since_change++;
            if (com != last_com) begin
                check_value("com order", next_com(last_com), com);
                if (seen_change)
                    check_value("com spacing", 1, since_change >= SCAN_PERIOD);
                seen_change  = 1'b1;
                since_change = 0;
            end
            shown = prev_hex ? bcd_t'(prev_count) : to_decimal(prev_count);
            check_value(prev_hex ? "hex seg_7" : "decimal seg_7",
                        seg_pattern(pick_nibble(prev_com, shown)), seg_7);
            last_com   = com;
            last_count = count;
        end
    end

    initial begin
        void'($urandom(32'hc35a7cd9));
        clk      = 1'b0;
        reset_p  = 1'b1;
        run      = 1'b0;
        hex_mode = 1'b0;
        hex_left = 300;
        cycles   = 0;
        wrapped  = 1'b0;
        repeat (10) @(posedge clk);
        reset_p <= 1'b0;
        @(negedge clk);
        check_value("reset com", 4'b1110, com);
        check_value("reset count", 0, count);
        check_value("reset seg_7", 8'h03, seg_7);
        wait (wrapped);
        repeat (50) @(posedge clk); // keep checking a little past the wrap
        $display("Test OK");
        $finish;
    end

endmodule : fnd_counter_tb

`default_nettype wire

//--- filelist.f
+incdir+src
src/fnd_pkg.sv
src/tick_counter.sv
src/bin_to_bcd.sv
src/digit_scanner.sv
src/seg_decoder.sv
src/fnd_counter_top.sv
sim/fnd_counter_tb.sv

//--- Bender.yml
package:
  name: fnd_counter

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fnd_pkg.sv
      - src/tick_counter.sv
      - src/bin_to_bcd.sv
      - src/digit_scanner.sv
      - src/seg_decoder.sv
      - src/fnd_counter_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/fnd_counter_tb.sv
